// File: design/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    // {rd, sel}
    typedef logic [7:0]  cp0_addr_t;

    localparam reg_addr_t LINK_REG = 5'd31;

    // COP0 CO funct for ERET, same code as MULT in the SPECIAL group
    localparam logic [5:0] FUNCT_ERET = 6'h18;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_COP0    = 6'h10,
        OP_BEQL    = 6'h14,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } op_code_t;

    typedef enum logic [5:0] {
        F_SLL     = 6'h00,
        F_SRL     = 6'h02,
        F_SRA     = 6'h03,
        F_SLLV    = 6'h04,
        F_SRLV    = 6'h06,
        F_SRAV    = 6'h07,
        F_JR      = 6'h08,
        F_JALR    = 6'h09,
        F_MOVZ    = 6'h0a,
        F_MOVN    = 6'h0b,
        F_SYSCALL = 6'h0c,
        F_BREAK   = 6'h0d,
        F_MFHI    = 6'h10,
        F_MTHI    = 6'h11,
        F_MFLO    = 6'h12,
        F_MTLO    = 6'h13,
        F_MULT    = 6'h18,
        F_MULTU   = 6'h19,
        F_DIV     = 6'h1a,
        F_DIVU    = 6'h1b,
        F_ADD     = 6'h20,
        F_ADDU    = 6'h21,
        F_SUB     = 6'h22,
        F_SUBU    = 6'h23,
        F_AND     = 6'h24,
        F_OR      = 6'h25,
        F_XOR     = 6'h26,
        F_NOR     = 6'h27,
        F_SLT     = 6'h2a,
        F_SLTU    = 6'h2b
    } funct_t;

    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_t;

    typedef enum logic [4:0] {
        C0_MF = 5'h00,
        C0_MT = 5'h04,
        C0_CO = 5'h10
    } cop0_rs_t;

    typedef struct packed {
        op_code_t  op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_t    funct;
    } r_fields_t;

    typedef struct packed {
        op_code_t    op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef struct packed {
        op_code_t    op;
        logic [25:0] target;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_LUI, ALU_PASSA, ALU_PASSB
    } alu_func_t;

    typedef enum logic {REGB, IMM} alu_src_t;
    typedef enum logic [1:0] {MSIZE1, MSIZE2, MSIZE4} msize_t;
    typedef enum logic [2:0] {T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ} branch_t;
    typedef enum logic [1:0] {CT_NONE, CT_INSTR, CT_EXCEPTION, CT_ERET} ctype_t;

    typedef struct packed {
        alu_func_t alufunc;
        alu_src_t  alusrc;
        logic      zeroext;
        logic      shamt_valid;
        logic      regwrite;
        logic      memtoreg;
        logic      memwrite;
        msize_t    msize;
        logic      memsext;
        logic      branch;
        branch_t   branch_type;
        logic      jump;
        logic      jr;
        logic      is_link;
        logic      hiwrite;
        logic      lowrite;
        logic      hitoreg;
        logic      lotoreg;
        logic      mul;
        logic      div;
        logic      signed_mul_div;
        logic      cp0write;
        logic      cp0toreg;
        logic      is_eret;
    } control_t;

    typedef struct packed {
        ctype_t ctype;
        logic   bp;
        logic   syscall;
        logic   reserved;
    } exc_t;

    // one group's view of the word; hit says the encoding belongs to it
    typedef struct packed {
        control_t  ctl;
        reg_addr_t srca;
        reg_addr_t srcb;
        reg_addr_t dest;
        exc_t      exc;
        logic      hit;
    } partial_t;

    typedef struct packed {
        control_t  ctl;
        reg_addr_t srca;
        reg_addr_t srcb;
        reg_addr_t dest;
        cp0_addr_t cp0ra;
        exc_t      exc;
    } decoded_t;

endpackage

// File: design/special_decoder.sv
module special_decoder (
    input  decode_pkg::instr_t   instr,
    output decode_pkg::partial_t part
);
    import decode_pkg::*;

    function automatic alu_func_t alu_of(funct_t f);
        case (f)
            F_ADD:         return ALU_ADD;
            F_ADDU:        return ALU_ADDU;
            F_SUB:         return ALU_SUB;
            F_SUBU:        return ALU_SUBU;
            F_SLT:         return ALU_SLT;
            F_SLTU:        return ALU_SLTU;
            F_AND:         return ALU_AND;
            F_OR:          return ALU_OR;
            F_XOR:         return ALU_XOR;
            F_NOR:         return ALU_NOR;
            F_SLL, F_SLLV: return ALU_SLL;
            F_SRL, F_SRLV: return ALU_SRL;
            F_SRA, F_SRAV: return ALU_SRA;
            // movz/movn pass rs, the condition comes from rt
            default:       return ALU_PASSA;
        endcase
    endfunction

    always_comb begin
        part = '0;
        part.hit = 1'b1;
        case (instr.r.funct)
            F_ADD, F_ADDU, F_SUB, F_SUBU, F_SLT, F_SLTU,
            F_AND, F_OR, F_XOR, F_NOR, F_SLLV, F_SRLV, F_SRAV,
            F_MOVZ, F_MOVN: begin
                part.ctl.alufunc = alu_of(instr.r.funct);
                part.ctl.regwrite = 1'b1;
                part.ctl.alusrc = REGB;
                part.srca = instr.r.rs;
                part.srcb = instr.r.rt;
                part.dest = instr.r.rd;
            end
            // shift by shamt
            F_SLL, F_SRL, F_SRA: begin
                part.ctl.alufunc = alu_of(instr.r.funct);
                part.ctl.regwrite = 1'b1;
                part.ctl.shamt_valid = 1'b1;
                part.srcb = instr.r.rt;
                part.dest = instr.r.rd;
            end
            F_MULT, F_MULTU, F_DIV, F_DIVU: begin
                part.ctl.hiwrite = 1'b1;
                part.ctl.lowrite = 1'b1;
                part.ctl.mul = (instr.r.funct == F_MULT) || (instr.r.funct == F_MULTU);
                part.ctl.div = (instr.r.funct == F_DIV) || (instr.r.funct == F_DIVU);
                part.ctl.signed_mul_div = (instr.r.funct == F_MULT) || (instr.r.funct == F_DIV);
                part.srca = instr.r.rs;
                part.srcb = instr.r.rt;
            end
            F_MFHI, F_MFLO: begin
                part.ctl.regwrite = 1'b1;
                part.ctl.hitoreg = (instr.r.funct == F_MFHI);
                part.ctl.lotoreg = (instr.r.funct == F_MFLO);
                part.ctl.alufunc = (instr.r.funct == F_MFHI) ? ALU_PASSA : ALU_PASSB;
                part.dest = instr.r.rd;
            end
            F_MTHI, F_MTLO: begin
                part.ctl.hiwrite = (instr.r.funct == F_MTHI);
                part.ctl.lowrite = (instr.r.funct == F_MTLO);
                part.ctl.alufunc = ALU_PASSA;
                part.srca = instr.r.rs;
            end
            F_JR, F_JALR: begin
                part.ctl.jump = 1'b1;
                part.ctl.jr = 1'b1;
                part.srca = instr.r.rs;
                if (instr.r.funct == F_JALR) begin
                    part.ctl.regwrite = 1'b1;
                    part.ctl.is_link = 1'b1;
                    part.dest = instr.r.rd;
                end
            end
            F_SYSCALL, F_BREAK: begin
                part.ctl.alufunc = ALU_PASSA;
                part.exc.ctype = CT_EXCEPTION;
                part.exc.syscall = (instr.r.funct == F_SYSCALL);
                part.exc.bp = (instr.r.funct == F_BREAK);
            end
            default: part.hit = 1'b0;
        endcase
    end

endmodule

// File: design/imm_decoder.sv
module imm_decoder (
    input  decode_pkg::instr_t   instr,
    output decode_pkg::partial_t part
);
    import decode_pkg::*;

    always_comb begin
        part = '0;
        part.hit = 1'b1;
        case (instr.i.op)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                part.ctl.regwrite = 1'b1;
                part.ctl.alusrc = IMM;
                part.srca = instr.i.rs;
                part.dest = instr.i.rt;
                case (instr.i.op)
                    OP_ADDI:  part.ctl.alufunc = ALU_ADD;
                    OP_ADDIU: part.ctl.alufunc = ALU_ADDU;
                    OP_SLTI:  part.ctl.alufunc = ALU_SLT;
                    OP_SLTIU: part.ctl.alufunc = ALU_SLTU;
                    OP_ANDI:  part.ctl.alufunc = ALU_AND;
                    OP_ORI:   part.ctl.alufunc = ALU_OR;
                    OP_XORI:  part.ctl.alufunc = ALU_XOR;
                    default:  part.ctl.alufunc = ALU_LUI;
                endcase
                // logical ops zero-extend imm16
                part.ctl.zeroext = (instr.i.op == OP_ANDI) || (instr.i.op == OP_ORI)
                                   || (instr.i.op == OP_XORI);
                if (instr.i.op == OP_LUI) begin
                    part.srca = '0;
                end
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                part.ctl.regwrite = 1'b1;
                part.ctl.memtoreg = 1'b1;
                part.ctl.alusrc = IMM;
                part.srca = instr.i.rs;
                part.dest = instr.i.rt;
                part.ctl.memsext = (instr.i.op == OP_LB) || (instr.i.op == OP_LH);
                if (instr.i.op == OP_LW) begin
                    part.ctl.msize = MSIZE4;
                end else if (instr.i.op == OP_LH || instr.i.op == OP_LHU) begin
                    part.ctl.msize = MSIZE2;
                end
            end
            OP_SB, OP_SH, OP_SW: begin
                part.ctl.memwrite = 1'b1;
                part.ctl.alusrc = IMM;
                part.srca = instr.i.rs;
                part.srcb = instr.i.rt;
                if (instr.i.op == OP_SW) begin
                    part.ctl.msize = MSIZE4;
                end else if (instr.i.op == OP_SH) begin
                    part.ctl.msize = MSIZE2;
                end
            end
            OP_BEQ, OP_BEQL, OP_BNE: begin
                part.ctl.branch = 1'b1;
                part.ctl.branch_type = (instr.i.op == OP_BNE) ? T_BNE : T_BEQ;
                part.srca = instr.i.rs;
                part.srcb = instr.i.rt;
            end
            OP_BGTZ, OP_BLEZ: begin
                part.ctl.branch = 1'b1;
                part.ctl.branch_type = (instr.i.op == OP_BGTZ) ? T_BGTZ : T_BLEZ;
                part.srca = instr.i.rs;
            end
            OP_REGIMM: begin
                part.ctl.branch = 1'b1;
                part.srca = instr.i.rs;
                case (instr.i.rt)
                    RI_BGEZ, RI_BGEZAL: part.ctl.branch_type = T_BGEZ;
                    RI_BLTZ, RI_BLTZAL: part.ctl.branch_type = T_BLTZ;
                    default:            part.hit = 1'b0;
                endcase
                // linking forms write the return address
                if (instr.i.rt == RI_BGEZAL || instr.i.rt == RI_BLTZAL) begin
                    part.ctl.regwrite = 1'b1;
                    part.ctl.is_link = 1'b1;
                    part.dest = LINK_REG;
                end
            end
            OP_J: part.ctl.jump = 1'b1;
            OP_JAL: begin
                part.ctl.jump = 1'b1;
                part.ctl.regwrite = 1'b1;
                part.ctl.is_link = 1'b1;
                part.dest = LINK_REG;
            end
            default: part.hit = 1'b0;
        endcase
    end

endmodule

// File: design/cop0_decoder.sv
module cop0_decoder (
    input  decode_pkg::instr_t    instr,
    output decode_pkg::partial_t  part,
    output decode_pkg::cp0_addr_t cp0ra
);
    import decode_pkg::*;

    // register number from rd, select from the low bits of the word
    assign cp0ra = {instr.r.rd, instr.i.imm16[2:0]};

    always_comb begin
        part = '0;
        part.hit = 1'b1;
        case (instr.r.rs)
            C0_MF: begin
                part.ctl.regwrite = 1'b1;
                part.ctl.cp0toreg = 1'b1;
                part.ctl.alufunc = ALU_PASSA;
                part.dest = instr.r.rt;
                part.exc.ctype = CT_INSTR;
            end
            C0_MT: begin
                part.ctl.cp0write = 1'b1;
                part.ctl.alufunc = ALU_PASSB;
                part.srcb = instr.r.rt;
                part.exc.ctype = CT_INSTR;
            end
            C0_CO: begin
                if (instr.r.funct == FUNCT_ERET) begin
                    part.ctl.is_eret = 1'b1;
                    part.exc.ctype = CT_ERET;
                end else begin
                    // tlb ops and wait land here
                    part.hit = 1'b0;
                end
            end
            default: part.hit = 1'b0;
        endcase
    end

endmodule

// File: design/decode_merge.sv
module decode_merge (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  decode_pkg::op_code_t  opcode,
    input  decode_pkg::partial_t  spec_part,
    input  decode_pkg::partial_t  imm_part,
    input  decode_pkg::partial_t  cop0_part,
    input  decode_pkg::cp0_addr_t cp0ra,
    output logic                  out_valid,
    output decode_pkg::decoded_t  decoded
);
    import decode_pkg::*;

    partial_t sel_part;
    decoded_t next_dec;

    always_comb begin
        case (opcode)
            OP_SPECIAL: sel_part = spec_part;
            OP_COP0:    sel_part = cop0_part;
            default:    sel_part = imm_part;
        endcase
    end

    always_comb begin
        next_dec = '0;
        if (sel_part.hit) begin
            next_dec.ctl = sel_part.ctl;
            next_dec.srca = sel_part.srca;
            next_dec.srcb = sel_part.srcb;
            next_dec.dest = sel_part.dest;
            next_dec.exc = sel_part.exc;
        end else begin
            // reserved instruction
            next_dec.ctl.alufunc = ALU_PASSA;
            next_dec.exc.ctype = CT_EXCEPTION;
            next_dec.exc.reserved = 1'b1;
        end
        next_dec.cp0ra = cp0ra;

        // r0 is hardwired
        if (next_dec.ctl.regwrite && next_dec.dest == '0) begin
            next_dec.ctl.regwrite = 1'b0;
        end

        if (!in_valid) begin
            next_dec = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            decoded <= '0;
        end else begin
            out_valid <= in_valid;
            decoded <= next_dec;
        end
    end

endmodule

// File: design/decoder_top.sv
module decoder_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  decode_pkg::instr_t   instr,
    output logic                 out_valid,
    output decode_pkg::decoded_t decoded
);
    import decode_pkg::*;

    partial_t  spec_part;
    partial_t  imm_part;
    partial_t  cop0_part;
    cp0_addr_t cp0ra;

    special_decoder i_special_decoder (
        .instr (instr),
        .part  (spec_part)
    );

    imm_decoder i_imm_decoder (
        .instr (instr),
        .part  (imm_part)
    );

    cop0_decoder i_cop0_decoder (
        .instr (instr),
        .part  (cop0_part),
        .cp0ra (cp0ra)
    );

    decode_merge i_decode_merge (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .opcode    (instr.r.op),
        .spec_part (spec_part),
        .imm_part  (imm_part),
        .cop0_part (cop0_part),
        .cp0ra     (cp0ra),
        .out_valid (out_valid),
        .decoded   (decoded)
    );

endmodule

// File: tb/decoder_assert.sv
module decoder_assert (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 out_valid,
    input decode_pkg::decoded_t decoded
);
    import decode_pkg::*;

    a_reset_clear: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    a_reserved: assert property (@(posedge clk) disable iff (!arst_n)
        decoded.exc.reserved |-> !decoded.ctl.regwrite && decoded.exc.ctype == CT_EXCEPTION)
        else $error("reserved instruction with regwrite or wrong ctype");

    a_store_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        decoded.ctl.memwrite |-> !decoded.ctl.regwrite)
        else $error("store also writes a register");

    a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
        decoded.ctl.regwrite |-> decoded.dest != 5'd0)
        else $error("regwrite with dest r0");

endmodule

bind decode_merge decoder_assert i_decoder_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .decoded   (decoded)
);

// File: tb/decoder_tb.sv
module decoder_tb;
    import decode_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int N_MIX = 400;
    localparam int N_B2B = 100;
    localparam int N_IDLE = 60;
    localparam int TIMEOUT = (RESET_CYCLES + N_MIX + N_B2B + N_IDLE + 20) * 10;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    instr_t   instr;
    logic     out_valid;
    decoded_t decoded;

    integer seed = 58767;
    int     pass_count = 0;
    int     fail_count = 0;

    logic [5:0] op_q[$];
    logic [5:0] funct_q[$];
    logic [4:0] regimm_q[$];
    logic [4:0] cop0_q[$];
    logic       exp_v_q[$];
    decoded_t   exp_d_q[$];

    decoder_top i_decoder_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .out_valid (out_valid),
        .decoded   (decoded)
    );

    always #5 clk = ~clk;

    // reference decode from the ISA rules
    function automatic decoded_t model(logic v, word_t w);
        decoded_t   d;
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic       hit;
        d = '0;
        op = w[31:26];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        fn = w[5:0];
        hit = 1'b1;
        if (!v) begin
            return d;
        end
        if (op == OP_SPECIAL) begin
            case (fn)
                F_ADD:  d.ctl.alufunc = ALU_ADD;
                F_ADDU: d.ctl.alufunc = ALU_ADDU;
                F_SUB:  d.ctl.alufunc = ALU_SUB;
                F_SUBU: d.ctl.alufunc = ALU_SUBU;
                F_SLT:  d.ctl.alufunc = ALU_SLT;
                F_SLTU: d.ctl.alufunc = ALU_SLTU;
                F_AND:  d.ctl.alufunc = ALU_AND;
                F_OR:   d.ctl.alufunc = ALU_OR;
                F_XOR:  d.ctl.alufunc = ALU_XOR;
                F_NOR:  d.ctl.alufunc = ALU_NOR;
                F_SLL, F_SLLV: d.ctl.alufunc = ALU_SLL;
                F_SRL, F_SRLV: d.ctl.alufunc = ALU_SRL;
                F_SRA, F_SRAV: d.ctl.alufunc = ALU_SRA;
                F_MOVZ, F_MOVN, F_MFHI, F_MTHI, F_MTLO, F_SYSCALL, F_BREAK:
                    d.ctl.alufunc = ALU_PASSA;
                F_MFLO: d.ctl.alufunc = ALU_PASSB;
                F_MULT, F_MULTU, F_DIV, F_DIVU, F_JR, F_JALR: ;
                default: hit = 1'b0;
            endcase
            if (fn inside {F_SLL, F_SRL, F_SRA}) begin
                d.ctl.shamt_valid = 1'b1;
                d.ctl.regwrite = 1'b1;
                d.srcb = rt;
                d.dest = rd;
            end else if (fn inside {F_MULT, F_MULTU, F_DIV, F_DIVU}) begin
                d.ctl.hiwrite = 1'b1;
                d.ctl.lowrite = 1'b1;
                d.ctl.mul = fn inside {F_MULT, F_MULTU};
                d.ctl.div = !d.ctl.mul;
                d.ctl.signed_mul_div = fn inside {F_MULT, F_DIV};
                d.srca = rs;
                d.srcb = rt;
            end else if (fn inside {F_MFHI, F_MFLO}) begin
                d.ctl.regwrite = 1'b1;
                d.ctl.hitoreg = (fn == F_MFHI);
                d.ctl.lotoreg = (fn == F_MFLO);
                d.dest = rd;
            end else if (fn inside {F_MTHI, F_MTLO}) begin
                d.ctl.hiwrite = (fn == F_MTHI);
                d.ctl.lowrite = (fn == F_MTLO);
                d.srca = rs;
            end else if (fn inside {F_JR, F_JALR}) begin
                d.ctl.jump = 1'b1;
                d.ctl.jr = 1'b1;
                d.srca = rs;
                d.ctl.regwrite = (fn == F_JALR);
                d.ctl.is_link = (fn == F_JALR);
                d.dest = (fn == F_JALR) ? rd : 5'd0;
            end else if (fn inside {F_SYSCALL, F_BREAK}) begin
                d.exc.ctype = CT_EXCEPTION;
                d.exc.syscall = (fn == F_SYSCALL);
                d.exc.bp = (fn == F_BREAK);
            end else if (hit) begin
                d.ctl.regwrite = 1'b1;
                d.srca = rs;
                d.srcb = rt;
                d.dest = rd;
            end
        end else if (op == OP_COP0) begin
            if (rs == C0_MF) begin
                d.ctl.regwrite = 1'b1;
                d.ctl.cp0toreg = 1'b1;
                d.ctl.alufunc = ALU_PASSA;
                d.dest = rt;
                d.exc.ctype = CT_INSTR;
            end else if (rs == C0_MT) begin
                d.ctl.cp0write = 1'b1;
                d.ctl.alufunc = ALU_PASSB;
                d.srcb = rt;
                d.exc.ctype = CT_INSTR;
            end else if (rs == C0_CO && fn == FUNCT_ERET) begin
                d.ctl.is_eret = 1'b1;
                d.exc.ctype = CT_ERET;
            end else begin
                hit = 1'b0;
            end
        end else if (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
            d.ctl.alufunc = alu_func_t'(op == OP_LUI ? ALU_LUI :
                            op == OP_ADDI ? ALU_ADD : op == OP_ADDIU ? ALU_ADDU :
                            op == OP_SLTI ? ALU_SLT : op == OP_SLTIU ? ALU_SLTU :
                            op == OP_ANDI ? ALU_AND : op == OP_ORI ? ALU_OR : ALU_XOR);
            d.ctl.alusrc = IMM;
            d.ctl.regwrite = 1'b1;
            d.ctl.zeroext = op inside {OP_ANDI, OP_ORI, OP_XORI};
            d.srca = (op == OP_LUI) ? 5'd0 : rs;
            d.dest = rt;
        end else if (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
                                OP_SB, OP_SH, OP_SW}) begin
            d.ctl.alusrc = IMM;
            d.srca = rs;
            d.ctl.msize = (op inside {OP_LW, OP_SW}) ? MSIZE4 :
                          (op inside {OP_LH, OP_LHU, OP_SH}) ? MSIZE2 : MSIZE1;
            if (op[3]) begin
                d.ctl.memwrite = 1'b1;
                d.srcb = rt;
            end else begin
                d.ctl.regwrite = 1'b1;
                d.ctl.memtoreg = 1'b1;
                d.ctl.memsext = op inside {OP_LB, OP_LH};
                d.dest = rt;
            end
        end else if (op inside {OP_BEQ, OP_BEQL, OP_BNE, OP_BGTZ, OP_BLEZ}) begin
            d.ctl.branch = 1'b1;
            d.srca = rs;
            d.srcb = (op inside {OP_BGTZ, OP_BLEZ}) ? 5'd0 : rt;
            d.ctl.branch_type = (op == OP_BNE) ? T_BNE : (op == OP_BGTZ) ? T_BGTZ :
                                (op == OP_BLEZ) ? T_BLEZ : T_BEQ;
        end else if (op == OP_REGIMM) begin
            if (rt inside {RI_BGEZ, RI_BGEZAL, RI_BLTZ, RI_BLTZAL}) begin
                d.ctl.branch = 1'b1;
                d.srca = rs;
                d.ctl.branch_type = rt[0] ? T_BGEZ : T_BLTZ;
                d.ctl.regwrite = rt[4];
                d.ctl.is_link = rt[4];
                d.dest = rt[4] ? LINK_REG : 5'd0;
            end else begin
                hit = 1'b0;
            end
        end else if (op inside {OP_J, OP_JAL}) begin
            d.ctl.jump = 1'b1;
            d.ctl.regwrite = (op == OP_JAL);
            d.ctl.is_link = (op == OP_JAL);
            d.dest = (op == OP_JAL) ? LINK_REG : 5'd0;
        end else begin
            hit = 1'b0;
        end
        if (!hit) begin
            d = '0;
            d.ctl.alufunc = ALU_PASSA;
            d.exc.ctype = CT_EXCEPTION;
            d.exc.reserved = 1'b1;
        end
        d.cp0ra = {rd, w[2:0]};
        if (d.dest == 5'd0) begin
            d.ctl.regwrite = 1'b0;
        end
        return d;
    endfunction

    task automatic gen_word(output word_t w);
        int pick;
        w = $random(seed);
        pick = $unsigned($random(seed)) % 40;
        // 28 of 40 words come from the code tables
        if (pick < 7) begin
            w[31:26] = OP_SPECIAL;
            w[5:0] = funct_q[$unsigned($random(seed)) % funct_q.size()];
        end else if (pick < 14) begin
            w[31:26] = op_q[$unsigned($random(seed)) % op_q.size()];
        end else if (pick < 21) begin
            w[31:26] = OP_REGIMM;
            w[20:16] = regimm_q[$unsigned($random(seed)) % regimm_q.size()];
        end else if (pick < 28) begin
            w[31:26] = OP_COP0;
            w[25:21] = cop0_q[$unsigned($random(seed)) % cop0_q.size()];
            if (pick[0]) begin
                w[5:0] = FUNCT_ERET;
            end
        end
        // now and then aim at r0
        if (($unsigned($random(seed)) % 8) == 0) begin
            w[20:11] = '0;
        end
    endtask

    task automatic check_out(logic exp_v, decoded_t exp_d);
        if (out_valid !== exp_v) begin
            $display("FAILED t=%0t out_valid exp=%b got=%b", $time, exp_v, out_valid);
            fail_count++;
        end else if (decoded !== exp_d) begin
            $display("FAILED t=%0t decoded exp=%h got=%h", $time, exp_d, decoded);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic run_stream(string name, int count, int valid_pct);
        word_t w;
        logic  v;
        int    err0;
        int    chk0;
        err0 = fail_count;
        chk0 = pass_count + fail_count;
        for (int i = 0; i <= count; i++) begin
            @(posedge clk);
            gen_word(w);
            v = (i < count) && (($unsigned($random(seed)) % 100) < valid_pct);
            in_valid <= v;
            instr <= w;
            exp_v_q.push_back(v);
            exp_d_q.push_back(model(v, w));
            @(negedge clk);
            if (exp_v_q.size() > 1) begin
                check_out(exp_v_q.pop_front(), exp_d_q.pop_front());
            end
        end
        $display("test %s: %0d checks, %0d errors", name,
                 pass_count + fail_count - chk0, fail_count - err0);
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish in %0d time units", TIMEOUT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        op_code_t op_e;
        funct_t   fn_e;
        regimm_t  ri_e;
        cop0_rs_t c0_e;
        int       err0;
        clk = 1'b0;
        arst_n = 1'b0;
        // valid addu held at the input during reset
        in_valid = 1'b1;
        instr = {OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, F_ADDU};
        op_e = op_e.first();
        repeat (op_e.num()) begin
            op_q.push_back(op_e);
            op_e = op_e.next();
        end
        fn_e = fn_e.first();
        repeat (fn_e.num()) begin
            funct_q.push_back(fn_e);
            fn_e = fn_e.next();
        end
        ri_e = ri_e.first();
        repeat (ri_e.num()) begin
            regimm_q.push_back(ri_e);
            ri_e = ri_e.next();
        end
        c0_e = c0_e.first();
        repeat (c0_e.num()) begin
            cop0_q.push_back(c0_e);
            c0_e = c0_e.next();
        end

        err0 = fail_count;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_out(1'b0, '0);
        @(posedge clk);
        arst_n <= 1'b1;
        in_valid <= 1'b0;
        @(negedge clk);
        check_out(1'b0, '0);
        $display("test reset: 2 checks, %0d errors", fail_count - err0);

        run_stream("random_mix", N_MIX, 85);
        run_stream("back_to_back", N_B2B, 100);
        run_stream("idle_gaps", N_IDLE, 30);

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
design/decode_pkg.sv
design/special_decoder.sv
design/imm_decoder.sv
design/cop0_decoder.sv
design/decode_merge.sv
design/decoder_top.sv
tb/decoder_assert.sv
tb/decoder_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module decoder_tb -f tb.f -o decoder_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/decoder_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
